/* cache/cache_cu.sv */
module cache_cu (
    input  logic                  clk,
    input  logic                  rst_n,
    input  mips_pkg::core_ctrl_t  ctrl,
    input  logic                  hit,
    input  logic                  dirty,
    output mips_pkg::cache_ctrl_t cctrl,
    output logic                  mem_write_en,
    output logic                  stall
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_WRITEBACK,
        S_FILL
    } state_e;

    state_e state_q;
    state_e state;
    logic   miss;

    assign miss  = (ctrl.mem_read || ctrl.mem_write) && !hit;
    assign stall = miss;

    // a miss is served in the cycle it shows up
    always_comb begin
        state = state_q;
        if (state_q == S_IDLE && miss) begin
            state = dirty ? S_WRITEBACK : S_FILL;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= (state == S_WRITEBACK) ? S_FILL : S_IDLE;
        end
    end

    assign mem_write_en      = (state == S_WRITEBACK);
    assign cctrl.mem_select  = (state == S_WRITEBACK);
    assign cctrl.fill_select = (state == S_FILL);
    assign cctrl.cache_we    = (state == S_FILL) ||
                               (state == S_IDLE && ctrl.mem_write && hit);

    a_wb_then_fill: assert property (@(posedge clk) disable iff (!rst_n)
        mem_write_en |-> (dirty && !hit) ##1 (cctrl.cache_we && cctrl.fill_select));

endmodule

/* cache/memory_datapath.sv */
`include "mips_settings.svh"

module memory_datapath (
    input  logic                   clk,
    input  logic                   rst_n,
    input  mips_pkg::cache_ctrl_t  cctrl,
    input  logic [`MIPS_XLEN-1:0]  data_addr,
    input  mips_pkg::mem_word_t    store_data,
    output mips_pkg::mem_word_t    load_data,
    output logic                   hit,
    output logic                   dirty,
    output logic [`MIPS_XLEN-1:0]  mem_addr,
    output mips_pkg::mem_word_t    mem_wdata,
    input  mips_pkg::mem_word_t    mem_rdata
);

    localparam int IDX_W = $clog2(`MIPS_CACHE_LINES);
    localparam int TAG_W = `MIPS_XLEN - IDX_W - 2;

    logic [TAG_W-1:0]             tag_arr [`MIPS_CACHE_LINES];
    mips_pkg::mem_word_t          data_arr [`MIPS_CACHE_LINES];
    logic [`MIPS_CACHE_LINES-1:0] valid_q;
    logic [`MIPS_CACHE_LINES-1:0] dirty_q;
    logic [IDX_W-1:0]             idx;
    logic [TAG_W-1:0]             tag;

    assign idx = data_addr[IDX_W+1:2];            // word index
    assign tag = data_addr[`MIPS_XLEN-1:IDX_W+2];

    assign hit       = valid_q[idx] && (tag_arr[idx] == tag);
    assign dirty     = valid_q[idx] && dirty_q[idx];
    assign load_data = data_arr[idx];

    ////////////////////
    // memory side

    assign mem_wdata = data_arr[idx];             // victim word
    assign mem_addr  = cctrl.mem_select ? {tag_arr[idx], idx, 2'b00}
                                        : {tag, idx, 2'b00};

    always_ff @(posedge clk) begin
        if (cctrl.cache_we) begin
            data_arr[idx] <= cctrl.fill_select ? mem_rdata : store_data;
            if (cctrl.fill_select) begin
                tag_arr[idx] <= tag;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (cctrl.cache_we) begin
            valid_q[idx] <= 1'b1;
            dirty_q[idx] <= !cctrl.fill_select;   // store hit dirties, fill cleans
        end
    end

endmodule

/* common/mips_pkg.sv */
package mips_pkg;

    ////////////////////
    // instruction encodings

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDIU = 6'h09,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL     = 6'h00,
        FN_SYSCALL = 6'h0c,   // used as halt
        FN_ADDU    = 6'h21,
        FN_SUBU    = 6'h23,
        FN_AND     = 6'h24,
        FN_OR      = 6'h25,
        FN_SLT     = 6'h2a
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_SLT = 4'd4,
        ALU_SLL = 4'd5
    } alu_op_e;

    typedef struct packed {
        opcode_e    opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        funct_e     funct;
    } r_fmt_t;

    typedef struct packed {
        opcode_e     opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;   // j target continues down from rs
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } inst_u;

    ////////////////////
    // buses and control

    typedef struct packed {
        logic [7:0] b3;
        logic [7:0] b2;
        logic [7:0] b1;
        logic [7:0] b0;
    } mem_word_t;

    typedef struct packed {
        logic    alu_src;     // immediate operand
        logic    reg_dest;    // write rd instead of rt
        logic    mem_to_reg;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    branch_eq;
        logic    branch_ne;
        logic    jump;
        logic    shift_amt;   // shift rt by shamt
        alu_op_e alu_op;
    } core_ctrl_t;

    typedef struct packed {
        logic cache_we;
        logic fill_select;    // line data comes from memory
        logic mem_select;     // memory address is the victim
    } cache_ctrl_t;

endpackage

/* common/mips_settings.svh */
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

////////////////////
// core sizes

`define MIPS_XLEN 32          // data and address width, one word
`define MIPS_NREGS 32         // general purpose registers, r0 reads zero

////////////////////
// data cache

`define MIPS_CACHE_LINES 8    // one word per line, keep a power of two

////////////////////
// fetch

`define MIPS_RESET_PC 32'h0000_0000

`endif

/* design/control_unit.sv */
module control_unit (
    input  logic                 clk,
    input  logic                 rst_n,
    input  mips_pkg::inst_u      inst,
    input  logic                 stall,
    output mips_pkg::core_ctrl_t ctrl,
    output logic                 halted
);

    mips_pkg::core_ctrl_t dec;
    logic                 is_syscall;

    assign is_syscall = (inst.r.opcode == mips_pkg::OP_RTYPE) &&
                        (inst.r.funct == mips_pkg::FN_SYSCALL);

    ////////////////////
    // decode

    always_comb begin
        dec = '0;
        dec.alu_op = mips_pkg::ALU_ADD;
        case (inst.i.opcode)
            mips_pkg::OP_RTYPE: begin
                dec.reg_dest  = 1'b1;
                dec.reg_write = 1'b1;
                case (inst.r.funct)
                    mips_pkg::FN_ADDU: dec.alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUBU: dec.alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND:  dec.alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:   dec.alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_SLT:  dec.alu_op = mips_pkg::ALU_SLT;
                    mips_pkg::FN_SLL: begin
                        dec.alu_op    = mips_pkg::ALU_SLL;
                        dec.shift_amt = 1'b1;
                    end
                    default: dec.reg_write = 1'b0;   // syscall, unknown funct
                endcase
            end
            mips_pkg::OP_ADDIU: begin
                dec.alu_src   = 1'b1;
                dec.reg_write = 1'b1;
            end
            mips_pkg::OP_LW: begin
                dec.alu_src    = 1'b1;
                dec.reg_write  = 1'b1;
                dec.mem_read   = 1'b1;
                dec.mem_to_reg = 1'b1;
            end
            mips_pkg::OP_SW: begin
                dec.alu_src   = 1'b1;
                dec.mem_write = 1'b1;
            end
            mips_pkg::OP_BEQ: begin
                dec.alu_op    = mips_pkg::ALU_SUB;
                dec.branch_eq = 1'b1;
            end
            mips_pkg::OP_BNE: begin
                dec.alu_op    = mips_pkg::ALU_SUB;
                dec.branch_ne = 1'b1;
            end
            mips_pkg::OP_J: dec.jump = 1'b1;
            default: ;                                // no-op
        endcase
    end

    assign ctrl = halted ? '0 : dec;   // nothing retires once halted

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            halted <= 1'b0;
        end else if (is_syscall && !stall) begin
            halted <= 1'b1;
        end
    end

    a_one_mem_op: assert property (@(posedge clk) disable iff (!rst_n)
        !(ctrl.mem_read && ctrl.mem_write));

endmodule

/* design/data_path.sv */
`include "mips_settings.svh"

module data_path (
    input  logic                   clk,
    input  logic                   rst_n,
    input  mips_pkg::inst_u        inst,
    input  mips_pkg::core_ctrl_t   ctrl,
    input  logic                   stall,
    input  logic                   halted,
    output logic [`MIPS_XLEN-1:0]  inst_addr,
    output logic [`MIPS_XLEN-1:0]  data_addr,
    output mips_pkg::mem_word_t    store_data,
    input  mips_pkg::mem_word_t    load_data
);

    localparam int REG_W = $clog2(`MIPS_NREGS);

    logic [`MIPS_XLEN-1:0] pc_q;
    logic [`MIPS_XLEN-1:0] pc_next;
    logic [`MIPS_XLEN-1:0] pc_plus4;
    logic [`MIPS_XLEN-1:0] branch_target;
    logic [`MIPS_XLEN-1:0] jump_target;
    logic [`MIPS_XLEN-1:0] regs [`MIPS_NREGS];
    logic [`MIPS_XLEN-1:0] rs_val;
    logic [`MIPS_XLEN-1:0] rt_val;
    logic [`MIPS_XLEN-1:0] imm_ext;
    logic [`MIPS_XLEN-1:0] op_a;
    logic [`MIPS_XLEN-1:0] op_b;
    logic [`MIPS_XLEN-1:0] alu_result;
    logic [`MIPS_XLEN-1:0] load_word;
    logic [`MIPS_XLEN-1:0] wb_data;
    logic [REG_W-1:0]      wb_reg;
    logic                  take_branch;
    logic                  reg_we;

    ////////////////////
    // operands

    assign rs_val  = regs[inst.i.rs];
    assign rt_val  = regs[inst.i.rt];
    assign imm_ext = {{(`MIPS_XLEN-16){inst.i.imm16[15]}}, inst.i.imm16};

    assign op_a = ctrl.shift_amt ? rt_val : rs_val;
    assign op_b = ctrl.alu_src   ? imm_ext :
                  ctrl.shift_amt ? {{(`MIPS_XLEN-5){1'b0}}, inst.r.shamt} : rt_val;

    always_comb begin
        case (ctrl.alu_op)
            mips_pkg::ALU_ADD: alu_result = op_a + op_b;
            mips_pkg::ALU_SUB: alu_result = op_a - op_b;
            mips_pkg::ALU_AND: alu_result = op_a & op_b;
            mips_pkg::ALU_OR:  alu_result = op_a | op_b;
            mips_pkg::ALU_SLT: alu_result = {{(`MIPS_XLEN-1){1'b0}},
                                             $signed(op_a) < $signed(op_b)};
            mips_pkg::ALU_SLL: alu_result = op_a << op_b[4:0];
            default:           alu_result = '0;
        endcase
    end

    assign data_addr  = alu_result;
    assign store_data = rt_val;
    assign load_word  = load_data;

    ////////////////////
    // register file

    assign wb_reg  = ctrl.reg_dest ? inst.r.rd : inst.r.rt;
    assign wb_data = ctrl.mem_to_reg ? load_word : alu_result;
    assign reg_we  = ctrl.reg_write && !stall && (wb_reg != '0);   // r0 stays zero

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < `MIPS_NREGS; k++) begin
                regs[k] <= '0;
            end
        end else if (reg_we) begin
            regs[wb_reg] <= wb_data;
        end
    end

    ////////////////////
    // next pc

    assign pc_plus4      = pc_q + `MIPS_XLEN'd4;
    assign branch_target = pc_plus4 + {imm_ext[`MIPS_XLEN-3:0], 2'b00};
    assign jump_target   = {pc_plus4[`MIPS_XLEN-1:28], inst.i.rs, inst.i.rt,
                            inst.i.imm16, 2'b00};
    assign take_branch   = (ctrl.branch_eq && (alu_result == '0)) ||
                           (ctrl.branch_ne && (alu_result != '0));

    assign pc_next = ctrl.jump   ? jump_target :
                     take_branch ? branch_target : pc_plus4;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= `MIPS_RESET_PC;
        end else if (!stall && !halted) begin
            pc_q <= pc_next;
        end
    end

    assign inst_addr = pc_q;

    // stall comes from the cache controller
    a_pc_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (stall || halted) |=> $stable(pc_q));

endmodule

/* design/mips_core.sv */
`include "mips_settings.svh"

module mips_core (
    input  logic                   clk,
    input  logic                   rst_n,
    output logic [`MIPS_XLEN-1:0]  inst_addr,
    input  logic [`MIPS_XLEN-1:0]  inst,
    output logic [`MIPS_XLEN-1:0]  mem_addr,
    input  mips_pkg::mem_word_t    mem_rdata,
    output mips_pkg::mem_word_t    mem_wdata,
    output logic                   mem_write_en,
    output logic                   halted
);

    mips_pkg::core_ctrl_t   ctrl;
    mips_pkg::cache_ctrl_t  cctrl;
    logic                   stall;
    logic                   hit;
    logic                   dirty;
    logic [`MIPS_XLEN-1:0]  data_addr;
    mips_pkg::mem_word_t    store_data;
    mips_pkg::mem_word_t    load_data;

    ////////////////////
    // core pair

    control_unit u_control_unit (
        .clk    (clk),
        .rst_n  (rst_n),
        .inst   (inst),
        .stall  (stall),
        .ctrl   (ctrl),
        .halted (halted)
    );

    data_path u_data_path (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst       (inst),
        .ctrl       (ctrl),
        .stall      (stall),
        .halted     (halted),
        .inst_addr  (inst_addr),
        .data_addr  (data_addr),
        .store_data (store_data),
        .load_data  (load_data)
    );

    ////////////////////
    // cache pair

    memory_datapath u_memory_datapath (
        .clk        (clk),
        .rst_n      (rst_n),
        .cctrl      (cctrl),
        .data_addr  (data_addr),
        .store_data (store_data),
        .load_data  (load_data),
        .hit        (hit),
        .dirty      (dirty),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata)
    );

    cache_cu u_cache_cu (
        .clk          (clk),
        .rst_n        (rst_n),
        .ctrl         (ctrl),
        .hit          (hit),
        .dirty        (dirty),
        .cctrl        (cctrl),
        .mem_write_en (mem_write_en),
        .stall        (stall)
    );

endmodule

/* flist.f */
+incdir+common
+incdir+tests
common/mips_pkg.sv
design/control_unit.sv
design/data_path.sv
cache/memory_datapath.sv
cache/cache_cu.sv
design/mips_core.sv
tests/mips_core_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module mips_core_tb \
    -f flist.f -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/Vmips_core_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "test failed" sim.log; then
    exit 1
fi
exit 0

/* tests/mips_ref_model.svh */
`ifndef MIPS_REF_MODEL_SVH
`define MIPS_REF_MODEL_SVH

////////////////////
// instruction level model of the core

// runs rom[] from reset, fills exp_pcs and exp_mem, returns the retired count
function automatic int ref_execute();
    logic [31:0] regs [32];
    logic [31:0] pc;
    logic [31:0] next_pc;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] addr;
    int          count;
    bit          done;
    for (int k = 0; k < 32; k++) begin
        regs[k] = '0;
    end
    for (int k = 0; k < DMEM_WORDS; k++) begin
        exp_mem[k] = word_fill(k);
    end
    exp_pcs.delete();
    pc    = `MIPS_RESET_PC;
    count = 0;
    done  = 0;
    while (!done && count < 4000) begin
        w       = rom[pc[9:2]];
        a       = regs[w[25:21]];
        b       = regs[w[20:16]];
        imm     = {{16{w[15]}}, w[15:0]};
        addr    = a + imm;
        next_pc = pc + 32'd4;
        count++;
        case (w[31:26])
            6'h00: begin
                case (w[5:0])
                    6'h21: regs[w[15:11]] = a + b;
                    6'h23: regs[w[15:11]] = a - b;
                    6'h24: regs[w[15:11]] = a & b;
                    6'h25: regs[w[15:11]] = a | b;
                    6'h2a: regs[w[15:11]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    6'h00: regs[w[15:11]] = b << w[10:6];
                    6'h0c: done = 1;   // halt, pc still steps once
                    default: ;
                endcase
            end
            6'h09: regs[w[20:16]] = addr;
            6'h23: regs[w[20:16]] = exp_mem[addr[13:2]];
            6'h2b: exp_mem[addr[13:2]] = b;
            6'h04: if (a == b) next_pc = next_pc + {imm[29:0], 2'b00};
            6'h05: if (a != b) next_pc = next_pc + {imm[29:0], 2'b00};
            6'h02: next_pc = {next_pc[31:28], w[25:0], 2'b00};
            default: ;
        endcase
        regs[0] = '0;
        exp_pcs.push_back(next_pc);
        pc = next_pc;
    end
    return count;
endfunction

`endif

/* tests/mips_core_tb.sv */
`include "mips_settings.svh"

module mips_core_tb;

    localparam int DMEM_WORDS = 4096;
    localparam logic [31:0] REGION_BASE = 32'h0000_1000;
    localparam logic [31:0] REGION_END  = 32'h0000_1040;   // 16 words

    logic                clk;
    logic                rst_n;
    logic [31:0]         inst_addr;
    logic [31:0]         inst;
    logic [31:0]         mem_addr;
    mips_pkg::mem_word_t mem_rdata;
    mips_pkg::mem_word_t mem_wdata;
    logic                mem_write_en;
    logic                halted;

    logic [31:0] rom [256];
    logic [31:0] dmem [DMEM_WORDS];
    logic [31:0] exp_mem [DMEM_WORDS];
    logic [31:0] exp_pcs [$];
    logic [31:0] prev_pc;
    int          n;
    int          ref_count;
    int          cycle_limit;
    int          cycles;
    int          trace_idx;
    bit          running;
    bit          halted_seen;

    function automatic logic [31:0] word_fill(int w);
        return (w * 32'h9e37_79b9) ^ 32'h5a5a_0000 ^ (w << 3);
    endfunction

    `include "mips_ref_model.svh"

    mips_core u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst_addr    (inst_addr),
        .inst         (inst),
        .mem_addr     (mem_addr),
        .mem_rdata    (mem_rdata),
        .mem_wdata    (mem_wdata),
        .mem_write_en (mem_write_en),
        .halted       (halted)
    );

    always #50 clk = ~clk;

    assign inst      = rom[inst_addr[9:2]];
    assign mem_rdata = dmem[mem_addr[13:2]];   // no wait states

    always @(posedge clk) begin
        if (rst_n && mem_write_en) begin
            dmem[mem_addr[13:2]] <= mem_wdata;
        end
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    ////////////////////
    // program generation

    function automatic logic [31:0] enc_r(int fn, int rd, int rs, int rt, int sh);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(sh), 6'(fn)};
    endfunction

    function automatic logic [31:0] enc_i(int op, int rs, int rt, logic [15:0] imm);
        return {6'(op), 5'(rs), 5'(rt), imm};
    endfunction

    task automatic emit(input logic [31:0] w);
        rom[n] = w;
        n++;
    endtask

    task automatic emit_random_op();
        int          kind;
        int          rd;
        int          rs;
        int          rt;
        logic [31:0] r;
        r    = $urandom;
        kind = int'(r % 8);
        rd   = 1 + int'((r >> 4) % 8);
        rs   = 1 + int'((r >> 8) % 8);
        rt   = 1 + int'((r >> 12) % 8);
        case (kind)
            0: emit(enc_r(6'h21, rd, rs, rt, 0));
            1: emit(enc_r(6'h23, rd, rs, rt, 0));
            2: emit(enc_r(6'h24, rd, rs, rt, 0));
            3: emit(enc_r(6'h25, rd, rs, rt, 0));
            4: emit(enc_r(6'h2a, rd, rs, rt, 0));
            5: emit(enc_r(6'h00, rd, 0, rt, int'((r >> 16) % 32)));
            6: emit(enc_i(6'h2b, 9, rt, 16'(4 * ((r >> 20) % 16))));   // sw
            default: emit(enc_i(6'h23, 9, rd, 16'(4 * ((r >> 20) % 16))));   // lw
        endcase
    endtask

    task automatic build_program();
        int loop_start;
        for (int k = 0; k < 256; k++) begin
            rom[k] = '0;
        end
        n = 0;
        for (int r = 1; r <= 8; r++) begin
            emit(enc_i(6'h09, 0, r, 16'($urandom)));
        end
        emit(enc_i(6'h09, 0, 9, REGION_BASE[15:0]));
        emit(enc_i(6'h09, 0, 10, 16'h2000));   // sweep base lies outside the region
        emit(enc_i(6'h09, 0, 11, 16'd3));      // loop count
        repeat (10) emit_random_op();
        loop_start = n;
        repeat (6) emit_random_op();
        emit(enc_i(6'h09, 11, 11, 16'hffff));
        emit(enc_i(6'h05, 11, 0, 16'(loop_start - (n + 1))));
        emit(enc_i(6'h04, 1, 1, 16'd1));
        emit(enc_i(6'h09, 2, 2, 16'($urandom)));
        emit(enc_i(6'h04, 2, 3, 16'd1));
        emit(enc_i(6'h09, 3, 3, 16'($urandom)));
        emit({6'h02, 26'(n + 2)});
        emit(enc_i(6'h09, 4, 4, 16'($urandom)));
        repeat (6) emit_random_op();
        // one lw per line pushes every dirty line out
        for (int k = 0; k < `MIPS_CACHE_LINES; k++) begin
            emit(enc_i(6'h23, 10, 12, 16'(4 * k)));
        end
        emit(enc_r(6'h0c, 0, 0, 0, 0));
    endtask

    ////////////////////
    // checks

    always @(negedge clk) begin
        if (rst_n && running) begin
            if (!halted) begin
                cycles++;
                if (cycles > cycle_limit) begin
                    stop_with_failure($sformatf("timeout, core did not halt in %0d cycles",
                                                cycle_limit));
                end
            end
            if (mem_write_en) begin
                assert (mem_addr >= REGION_BASE && mem_addr < REGION_END &&
                        mem_addr[1:0] == 2'b00)
                else stop_with_failure($sformatf("[ERROR] mem_addr outside data region %h",
                                                 mem_addr));
            end
            if (inst_addr != prev_pc) begin
                assert (trace_idx < exp_pcs.size())
                else stop_with_failure("pc kept changing after the reference trace ended");
                assert (inst_addr == exp_pcs[trace_idx])
                else stop_with_failure($sformatf("[ERROR] inst_addr expected %h got %h",
                                                 exp_pcs[trace_idx], inst_addr));
                trace_idx++;
                prev_pc = inst_addr;
            end
            if (halted_seen) begin
                assert (halted) else stop_with_failure("halted dropped after it was set");
            end
            if (halted) begin
                halted_seen = 1;
            end
        end
    end

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        running     = 0;
        halted_seen = 0;
        cycles      = 0;
        trace_idx   = 0;
        void'($urandom(32'h22705509));
        build_program();
        for (int k = 0; k < DMEM_WORDS; k++) begin
            dmem[k] = word_fill(k);
        end
        ref_count   = ref_execute();
        cycle_limit = 3 * ref_count + 20;
        prev_pc     = `MIPS_RESET_PC;
        repeat (10) @(posedge clk);
        @(negedge clk);
        assert (!halted && !mem_write_en && inst_addr == `MIPS_RESET_PC)
        else stop_with_failure($sformatf(
            "[ERROR] reset state halted %h mem_write_en %h inst_addr %h",
            halted, mem_write_en, inst_addr));
        @(posedge clk);
        rst_n   <= 1'b1;
        running = 1;
        while (!halted_seen) @(posedge clk);
        repeat (4) @(posedge clk);   // pc must sit still after halt
        assert (trace_idx == exp_pcs.size())
        else stop_with_failure($sformatf("pc trace too short, %0d of %0d",
                                         trace_idx, exp_pcs.size()));
        for (int k = 0; k < DMEM_WORDS; k++) begin
            assert (dmem[k] == exp_mem[k])
            else stop_with_failure($sformatf("[ERROR] dmem[%h] expected %h got %h",
                                             k * 4, exp_mem[k], dmem[k]));
        end
        $display("test passed");
        $finish;
    end

endmodule
